// ==== rtl/adc_sample_pkg.sv ====
/*
 * raw adc sample types
 * sample width, single sample, four-bus input set for one clock
 */

package adc_sample_pkg;

  // ------------------------------------------------------------------
  // sample width
  // ------------------------------------------------------------------

  localparam int SAMPLE_W = 8;  // adc08d-style 8-bit converter

  // one converter output word
  typedef logic [SAMPLE_W-1:0] sample_t;

  // ------------------------------------------------------------------
  // input sample set
  // ------------------------------------------------------------------

  // all four buses as they appear on one adc_clk edge
  // di/dq are the I and Q channels,
  // the _d buses carry the interleaved (delayed) companion samples
  typedef struct packed {
    sample_t di;    // I bus
    sample_t di_d;  // I delayed bus
    sample_t dq;    // Q bus
    sample_t dq_d;  // Q delayed bus
  } adc_in_t;

endpackage

// ==== rtl/adc_frame_pkg.sv ====
/*
 * frame level types and constants
 * slot count and index, per-bus frame, full 134-bit frame, fifo sizing
 */

package adc_frame_pkg;

  // ------------------------------------------------------------------
  // slot counting
  // ------------------------------------------------------------------

  localparam int SLOTS = 4;  // samples per bus per frame

  typedef logic [$clog2(SLOTS)-1:0] slot_t;  // 0..3

  // element n holds the sample taken in slot n
  typedef adc_sample_pkg::sample_t [SLOTS-1:0] bus_frame_t;

  // ------------------------------------------------------------------
  // frame word
  // ------------------------------------------------------------------

  // 4 buses x 4 slots x 8 bits + 4 sync + 2 overrange = 134 bits
  typedef struct packed {
    bus_frame_t       di;
    bus_frame_t       di_d;
    bus_frame_t       dq;
    bus_frame_t       dq_d;
    logic [SLOTS-1:0] sync;       // bit n = sync in slot n
    logic [1:0]       overrange;  // bit 0 = slots 0/1, bit 1 = slots 2/3
  } frame_t;

  // ------------------------------------------------------------------
  // fifo sizing
  // ------------------------------------------------------------------

  localparam int FIFO_DEPTH = 8;  // frames, power of two

  typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_cnt_t;  // 0..FIFO_DEPTH
  typedef logic [$clog2(FIFO_DEPTH)-1:0]   fifo_ptr_t;  // wraps at depth

endpackage

// ==== rtl/frame_deser.sv ====
/*
 * four-bus deserializer
 * slot counter, frame assembly with sync and overrange capture,
 * frame output register and optional extra register stage
 */

`timescale 1ns/1ns

module frame_deser #(
  parameter int EXTRA_REG = 1  // 1 = extra stage ahead of the fifo
) (
  input  logic                    adc_clk,
  input  logic                    dcm_reset,
  input  adc_sample_pkg::adc_in_t adc_in,
  input  logic                    adc_sync,
  input  logic                    adc_overrange,
  output adc_frame_pkg::frame_t   frame,
  output logic                    frame_valid
);

  // ------------------------------------------------------------------
  // slot counter
  // ------------------------------------------------------------------

  adc_frame_pkg::slot_t slot;
  logic                 last_slot;

  assign last_slot = (slot == adc_frame_pkg::slot_t'(adc_frame_pkg::SLOTS - 1));

  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      slot <= '0;  // first sample after reset is slot 0
    end else begin
      slot <= slot + 1'b1;  // wraps 3 -> 0
    end
  end

  // ------------------------------------------------------------------
  // frame assembly
  // ------------------------------------------------------------------

  adc_frame_pkg::frame_t frame_build;  // slots gathered so far
  adc_frame_pkg::frame_t frame_next;   // build plus current slot

  // drop this cycle's inputs into the current slot
  always_comb begin
    frame_next = frame_build;
    frame_next.di[slot]   = adc_in.di;
    frame_next.di_d[slot] = adc_in.di_d;
    frame_next.dq[slot]   = adc_in.dq;
    frame_next.dq_d[slot] = adc_in.dq_d;
    frame_next.sync[slot] = adc_sync;  // one sync bit per slot

    // overrange ORed per half frame, slot[1] picks the half
    if (slot[0]) begin
      frame_next.overrange[slot[1]] = frame_build.overrange[slot[1]] | adc_overrange;
    end else begin
      frame_next.overrange[slot[1]] = adc_overrange;  // first slot of half, restart
    end
  end

  // payload only, stale slots get overwritten before use
  always_ff @(posedge adc_clk) begin
    frame_build <= frame_next;
  end

  // ------------------------------------------------------------------
  // frame output register
  // ------------------------------------------------------------------

  adc_frame_pkg::frame_t frame_s1;
  logic                  valid_s1;

  always_ff @(posedge adc_clk) begin
    if (last_slot) begin
      frame_s1 <= frame_next;  // complete frame incl. slot 3
    end
  end

  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      valid_s1 <= 1'b0;
    end else begin
      valid_s1 <= last_slot;  // one pulse per frame
    end
  end

  // ------------------------------------------------------------------
  // optional extra stage, eases timing into the fifo
  // ------------------------------------------------------------------

  generate
    if (EXTRA_REG != 0) begin : g_extra_reg
      adc_frame_pkg::frame_t frame_s2;
      logic                  valid_s2;

      always_ff @(posedge adc_clk) begin
        frame_s2 <= frame_s1;
      end

      always_ff @(posedge adc_clk) begin
        if (dcm_reset) begin
          valid_s2 <= 1'b0;
        end else begin
          valid_s2 <= valid_s1;
        end
      end

      assign frame       = frame_s2;
      assign frame_valid = valid_s2;  // two cycles after slot 3
    end else begin : g_no_extra_reg
      assign frame       = frame_s1;
      assign frame_valid = valid_s1;  // one cycle after slot 3
    end
  endgenerate

endmodule

// ==== rtl/frame_fifo.sv ====
/*
 * single-clock frame buffer
 * circular store, drop-on-full with sticky overflow, valid/ready output
 */

`timescale 1ns/1ns

module frame_fifo (
  input  logic                  adc_clk,
  input  logic                  dcm_reset,
  input  adc_frame_pkg::frame_t frame,
  input  logic                  frame_valid,
  output adc_frame_pkg::frame_t out_frame,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic                  overflow
);

  // ------------------------------------------------------------------
  // storage and pointers
  // ------------------------------------------------------------------

  adc_frame_pkg::frame_t    mem [adc_frame_pkg::FIFO_DEPTH];
  adc_frame_pkg::fifo_ptr_t wr_ptr;
  adc_frame_pkg::fifo_ptr_t rd_ptr;
  adc_frame_pkg::fifo_cnt_t count;  // frames held

  logic full;
  logic wr_en;
  logic rd_en;

  assign full = (count == adc_frame_pkg::fifo_cnt_t'(adc_frame_pkg::FIFO_DEPTH));

  // ------------------------------------------------------------------
  // handshake decode
  // ------------------------------------------------------------------

  assign out_valid = (count != '0);
  assign rd_en     = out_valid & out_ready;  // head leaves this cycle

  // adc can't stall, so a full fifo just drops the frame
  // a read in the same cycle frees the slot, write goes through
  assign wr_en = frame_valid & (~full | rd_en);

  // head frame, only meaningful with out_valid
  assign out_frame = mem[rd_ptr];

  // ------------------------------------------------------------------
  // memory write
  // ------------------------------------------------------------------

  always_ff @(posedge adc_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= frame;
    end
  end

  // ------------------------------------------------------------------
  // pointers and count
  // ------------------------------------------------------------------

  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;  // power-of-two depth, natural wrap
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle, or read and write together
      endcase
    end
  end

  // ------------------------------------------------------------------
  // overflow flag
  // ------------------------------------------------------------------

  // sticky until reset, marks at least one lost frame
  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      overflow <= 1'b0;
    end else if (frame_valid & ~wr_en) begin
      overflow <= 1'b1;
    end
  end

endmodule

// ==== rtl/adc_capture_top.sv ====
/*
 * adc capture top level
 * deserializer into frame fifo, frame struct straight to the user port
 */

`timescale 1ns/1ns

module adc_capture_top #(
  parameter int EXTRA_REG = 1  // passed to the deserializer
) (
  // clock and reset
  input  logic                    adc_clk,
  input  logic                    dcm_reset,

  // adc side, sampled every edge, no handshake
  input  adc_sample_pkg::adc_in_t adc_in,
  input  logic                    adc_sync,
  input  logic                    adc_overrange,

  // user side stream
  output adc_frame_pkg::frame_t   out_frame,
  output logic                    out_valid,
  input  logic                    out_ready,
  output logic                    overflow  // sticky, frames were lost
);

  // ------------------------------------------------------------------
  // deserializer to fifo
  // ------------------------------------------------------------------

  adc_frame_pkg::frame_t deser_frame;
  logic                  deser_valid;  // one pulse per frame, never refused

  // capture and deserialize, plus optional register
  frame_deser #(
    .EXTRA_REG     (EXTRA_REG)
  ) u_frame_deser (
    .adc_clk       (adc_clk),
    .dcm_reset     (dcm_reset),
    .adc_in        (adc_in),
    .adc_sync      (adc_sync),
    .adc_overrange (adc_overrange),
    .frame         (deser_frame),
    .frame_valid   (deser_valid)
  );

  // ------------------------------------------------------------------
  // frame buffer, output packing is the frame struct itself
  // ------------------------------------------------------------------

  frame_fifo u_frame_fifo (
    .adc_clk     (adc_clk),
    .dcm_reset   (dcm_reset),
    .frame       (deser_frame),
    .frame_valid (deser_valid),
    .out_frame   (out_frame),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .overflow    (overflow)
  );

endmodule

// ==== sim/adc_capture_props.sv ====
/*
 * concurrent checks bound into the capture top level
 * stream idle after reset, stalled head holds, sticky overflow
 */

`timescale 1ns/1ns

module adc_capture_props (
  input logic                  adc_clk,
  input logic                  dcm_reset,
  input adc_frame_pkg::frame_t out_frame,
  input logic                  out_valid,
  input logic                  out_ready,
  input logic                  overflow
);

  // ------------------------------------------------------------------
  // output stream
  // ------------------------------------------------------------------

  // fifo comes out of reset empty
  a_idle_after_reset: assert property (
    @(posedge adc_clk) dcm_reset |=> !out_valid
  ) else $error("out_valid high in the cycle after reset");

  // head frame holds while the user stalls
  a_hold_when_stalled: assert property (
    @(posedge adc_clk) disable iff (dcm_reset)
      out_valid && !out_ready |=> out_valid && $stable(out_frame)
  ) else $error("stalled output frame changed or lost valid");

  // ------------------------------------------------------------------
  // overflow flag
  // ------------------------------------------------------------------

  a_overflow_sticky: assert property (
    @(posedge adc_clk) overflow && !dcm_reset |=> overflow
  ) else $error("overflow cleared without reset");

  a_overflow_reset: assert property (
    @(posedge adc_clk) dcm_reset |=> !overflow
  ) else $error("overflow high in the cycle after reset");

endmodule

bind adc_capture_top adc_capture_props u_props (
  .adc_clk   (adc_clk),
  .dcm_reset (dcm_reset),
  .out_frame (out_frame),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .overflow  (overflow)
);

// ==== sim/tb_adc_capture.sv ====
/*
 * adc capture testbench
 * clock, reset, random stimulus, reference frame model,
 * output comparison, six directed tests and a cycle watchdog
 */

`timescale 1ns/1ns

module tb_adc_capture;

  // ------------------------------------------------------------------
  // run constants
  // ------------------------------------------------------------------

  localparam logic [31:0] SEED = 32'h973c_d805;

  localparam int T1_FRAMES = 64;   // frame order
  localparam int T2_FRAMES = 32;   // sync
  localparam int T3_FRAMES = 40;   // overrange
  localparam int T4_FRAMES = 64;   // back-pressure
  localparam int T5_STALL  = 60;   // ready low for 15 frames
  localparam int T6_FRAMES = 8;    // after mid-frame reset

  localparam int TEST_CYC =
    4 * (T1_FRAMES + T2_FRAMES + T3_FRAMES + T4_FRAMES + T6_FRAMES) + T5_STALL;
  localparam int TIMEOUT_CYC = 2 * TEST_CYC + 200;

  localparam int READY_ON   = 0;
  localparam int READY_RAND = 1;  // low stretches of 1..16 cycles
  localparam int READY_OFF  = 2;

  typedef logic [2:0] test_id_t;

  localparam test_id_t T_ORDER = 3'd0;
  localparam test_id_t T_SYNC  = 3'd1;
  localparam test_id_t T_OVR   = 3'd2;
  localparam test_id_t T_BP    = 3'd3;
  localparam test_id_t T_OVF   = 3'd4;
  localparam test_id_t T_RST   = 3'd5;
  localparam test_id_t T_IDLE  = 3'd6;  // frames between tests

  // ------------------------------------------------------------------
  // DUT signals and bookkeeping
  // ------------------------------------------------------------------

  logic                    adc_clk = 1'b0;
  logic                    dcm_reset;
  adc_sample_pkg::adc_in_t adc_in;
  logic                    adc_sync;
  logic                    adc_overrange;
  adc_frame_pkg::frame_t   out_frame;
  logic                    out_valid;
  logic                    out_ready;
  logic                    overflow;

  logic     sync_rand  = 1'b0;
  logic     ovr_pulses = 1'b0;
  int       ready_mode = READY_ON;
  test_id_t test_id    = T_ORDER;  // tag for frames being built
  int       cyc        = 0;

  adc_frame_pkg::frame_t exp_q [$];   // expected frames in arrival order
  test_id_t              exp_id [$];  // owning test per frame

  int    pushed [8]  = '{default: 0};
  int    checked [8] = '{default: 0};
  int    errors [8]  = '{default: 0};
  int    chk_total   = 0;
  int    err_total   = 0;
  logic [1:0] ovr_seen = 2'b00;
  string names [8] = '{"frame_order", "sync_slots", "overrange_halves", "backpressure",
                       "overflow", "mid_frame_reset", "between_tests", "spare"};

  adc_capture_top #(
    .EXTRA_REG     (1)
  ) DUT (
    .adc_clk       (adc_clk),
    .dcm_reset     (dcm_reset),
    .adc_in        (adc_in),
    .adc_sync      (adc_sync),
    .adc_overrange (adc_overrange),
    .out_frame     (out_frame),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .overflow      (overflow)
  );

  always #2 adc_clk = ~adc_clk;  // 4 ns period

  // ------------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------------

  // slot n of every bus holds the n-th sample set
  function automatic adc_frame_pkg::frame_t ref_frame(
    input adc_sample_pkg::adc_in_t [3:0] sets,
    input logic [3:0]                    syncs,
    input logic [3:0]                    ovrs
  );
    adc_frame_pkg::frame_t f;
    adc_frame_pkg::slot_t  k;
    f = '0;
    for (int n = 0; n < adc_frame_pkg::SLOTS; n++) begin
      k = adc_frame_pkg::slot_t'(n);
      f.di[k]   = sets[k].di;
      f.di_d[k] = sets[k].di_d;
      f.dq[k]   = sets[k].dq;
      f.dq_d[k] = sets[k].dq_d;
    end
    f.sync         = syncs;              // bit n from slot n
    f.overrange[0] = ovrs[0] | ovrs[1];  // ORed per half frame
    f.overrange[1] = ovrs[2] | ovrs[3];
    return f;
  endfunction

  // ------------------------------------------------------------------
  // stimulus with one new sample set per edge
  // ------------------------------------------------------------------

  initial begin
    int stall_left;
    int run_left;
    void'($urandom(SEED));
    stall_left    = 0;
    run_left      = 0;
    adc_in        = '0;
    adc_sync      = 1'b0;
    adc_overrange = 1'b0;
    out_ready     = 1'b0;
    forever begin
      @(posedge adc_clk);
      adc_in        <= adc_sample_pkg::adc_in_t'($urandom);
      adc_sync      <= sync_rand && ($urandom_range(1, 0) == 1);
      adc_overrange <= ovr_pulses && (cyc % 5 == 0);  // walks through the slots
      case (ready_mode)
        READY_RAND: begin
          if (stall_left > 0) begin
            out_ready <= 1'b0;
            stall_left--;
          end else if (run_left > 0) begin
            out_ready <= 1'b1;
            run_left--;
          end else begin
            // new stall followed by at least 8 ready cycles to drain
            stall_left = $urandom_range(16, 1) - 1;
            run_left   = $urandom_range(24, 8);
            out_ready <= 1'b0;
          end
        end
        READY_OFF: out_ready <= 1'b0;
        default:   out_ready <= 1'b1;
      endcase
    end
  end

  // ------------------------------------------------------------------
  // input monitor that builds expected frames
  // ------------------------------------------------------------------

  adc_sample_pkg::adc_in_t [3:0] mon_sets;
  logic [3:0]                    mon_sync;
  logic [3:0]                    mon_ovr;
  adc_frame_pkg::slot_t          mon_slot = '0;  // slot of the next sample

  always @(posedge adc_clk) begin
    if (dcm_reset) begin
      mon_slot = '0;
      exp_q.delete();  // stored and in-flight frames are lost
      exp_id.delete();
    end else begin
      mon_sets[mon_slot] = adc_in;
      mon_sync[mon_slot] = adc_sync;
      mon_ovr[mon_slot]  = adc_overrange;
      if (mon_slot == 2'd3) begin
        exp_q.push_back(ref_frame(mon_sets, mon_sync, mon_ovr));
        exp_id.push_back(test_id);
        pushed[test_id]++;
      end
      mon_slot = mon_slot + 1'b1;
    end
  end

  // ------------------------------------------------------------------
  // output compare with one check per accepted transfer
  // ------------------------------------------------------------------

  always @(posedge adc_clk) begin : compare_outputs
    adc_frame_pkg::frame_t exp_frame;
    test_id_t              id;
    if (!dcm_reset && out_valid && out_ready) begin
      assert (exp_q.size() > 0) else begin
        errors[T_IDLE]++;
        err_total++;
        $display("ERROR: an output frame was delivered while no frame was expected");
      end
      if (exp_q.size() > 0) begin
        exp_frame = exp_q.pop_front();
        id        = exp_id.pop_front();
        // overflow test only vouches for the frames that fit
        if (!(id == T_OVF && checked[T_OVF] >= adc_frame_pkg::FIFO_DEPTH)) begin
          checked[id]++;
          chk_total++;
          if (id == T_OVR) ovr_seen |= out_frame.overrange;
          assert (out_frame == exp_frame) else begin
            errors[id]++;
            err_total++;
            $display("MISMATCH %s: expected %h, actual %h", names[id], exp_frame, out_frame);
          end
        end
      end
    end
  end

  // watchdog
  always @(posedge adc_clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      $display("ERROR: timeout, run passed %0d cycles while waiting for frames", TIMEOUT_CYC);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ------------------------------------------------------------------
  // sequencing helpers
  // ------------------------------------------------------------------

  task automatic do_reset();
    dcm_reset <= 1'b1;
    repeat (2) @(posedge adc_clk);
    dcm_reset <= 1'b0;
  endtask

  task automatic start_test(input test_id_t id, input logic sync_on, input logic ovr_on,
                            input int ready);
    @(posedge adc_clk);
    test_id    <= id;
    sync_rand  <= sync_on;
    ovr_pulses <= ovr_on;
    ready_mode <= ready;
  endtask

  // stop tagging and wait until every frame of the test came out
  task automatic wait_drained(input test_id_t id);
    @(posedge adc_clk);
    test_id    <= T_IDLE;
    ready_mode <= READY_ON;
    sync_rand  <= 1'b0;
    ovr_pulses <= 1'b0;
    @(negedge adc_clk);
    while (checked[id] != pushed[id]) @(negedge adc_clk);
  endtask

  task automatic note_failure(input test_id_t id, input string what);
    errors[id]++;
    err_total++;
    $display("ERROR: %s: %s", names[id], what);
  endtask

  task automatic report_test(input test_id_t id);
    $display("test %s done: %0d frames checked, %0d errors", names[id], checked[id], errors[id]);
  endtask

  // ------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------

  initial begin
    dcm_reset = 1'b1;
    do_reset();

    // random samples with ready always high
    repeat (4 * T1_FRAMES) @(posedge adc_clk);
    wait_drained(T_ORDER);
    report_test(T_ORDER);

    // random sync bits
    start_test(T_SYNC, 1'b1, 1'b0, READY_ON);
    repeat (4 * T2_FRAMES) @(posedge adc_clk);
    wait_drained(T_SYNC);
    report_test(T_SYNC);

    // single overrange pulses
    start_test(T_OVR, 1'b0, 1'b1, READY_ON);
    repeat (4 * T3_FRAMES) @(posedge adc_clk);
    wait_drained(T_OVR);
    assert (ovr_seen == 2'b11) else begin
      note_failure(T_OVR, "overrange pulses never reached both frame halves");
    end
    report_test(T_OVR);

    // random stalls below fifo depth
    start_test(T_BP, 1'b1, 1'b1, READY_RAND);
    repeat (4 * T4_FRAMES) @(posedge adc_clk);
    wait_drained(T_BP);
    assert (!overflow) else note_failure(T_BP, "overflow set although no frame was dropped");
    report_test(T_BP);

    // fresh reset and ready low long enough to overfill
    start_test(T_OVF, 1'b0, 1'b0, READY_OFF);
    do_reset();
    repeat (T5_STALL) @(posedge adc_clk);
    @(negedge adc_clk);
    assert (overflow) else note_failure(T_OVF, "overflow still low after the fifo overfilled");
    @(posedge adc_clk);
    ready_mode <= READY_ON;
    while (checked[T_OVF] < adc_frame_pkg::FIFO_DEPTH) @(negedge adc_clk);
    report_test(T_OVF);

    // reset with slots 0..2 of a frame taken
    while (mon_slot != 2'd2) @(negedge adc_clk);
    start_test(T_RST, 1'b1, 1'b1, READY_ON);
    do_reset();
    @(negedge adc_clk);
    assert (!out_valid && !overflow) else begin
      note_failure(T_RST, "out_valid or overflow still high after reset");
    end
    repeat (4 * T6_FRAMES) @(posedge adc_clk);
    wait_drained(T_RST);
    report_test(T_RST);

    $display("summary: 6 tests, %0d frames checked, %0d errors", chk_total, err_total);
    if (err_total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
rtl/adc_sample_pkg.sv
rtl/adc_frame_pkg.sv
rtl/frame_deser.sv
rtl/frame_fifo.sv
rtl/adc_capture_top.sv
sim/adc_capture_props.sv
sim/tb_adc_capture.sv

// ==== Makefile ====
# Verilator build and run of the adc capture testbench

VERILATOR ?= verilator
TOP       := tb_adc_capture
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert --top-module $(TOP)
LINTFLAGS := --lint-only --timing --assert -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: PASS" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
